//--- hdl/mc_pkg.sv
package mc_pkg;

  typedef logic [31:0] word_t;

  localparam int MEM_WORDS = 1024;

  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_LUI    = 7'b0110111,
    OPC_SYSTEM = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_t;

  typedef enum logic [3:0] {
    S_IDLE,
    S_FETCH,
    S_FETCH_WAIT,
    S_DECODE,
    S_EXEC_R,
    S_EXEC_I,
    S_MEM_ADDR,
    S_MEM_RD,
    S_MEM_RD_WAIT,
    S_MEM_WB,
    S_MEM_WR,
    S_ALU_WB,
    S_BRANCH,
    S_JUMP,
    S_HALT
  } fsm_state_t;

  typedef enum logic [1:0] {
    SRC_A_PC,
    SRC_A_OLD_PC,
    SRC_A_RS1,
    SRC_A_ZERO
  } alu_src_a_t;

  typedef enum logic [1:0] {
    SRC_B_RS2,
    SRC_B_IMM,
    SRC_B_FOUR
  } alu_src_b_t;

  typedef enum logic [1:0] {
    RES_ALU_OUT,
    RES_DATA,
    RES_ALU_RESULT
  } result_src_t;

  typedef enum logic {
    ADR_PC,
    ADR_RESULT
  } adr_src_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_t    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_t     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    opcode_t    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_t    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    opcode_t     opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    opcode_t    opcode;
  } j_fmt_t;

  // Same 32 bits, viewed per instruction format.
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_u;

endpackage

//--- hdl/mem_if.sv
`timescale 1ns/1ps

interface mem_if;
  import mc_pkg::*;

  logic  req;
  logic  we;
  word_t addr;
  word_t wdata;
  word_t rdata;
  logic  gnt;

  // Control side of the core.
  modport requester_ctrl (
    output req,
    output we,
    input  gnt
  );

  // Address and data side of the core.
  modport requester_data (
    output addr,
    output wdata,
    input  rdata
  );

  modport arbiter (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output gnt,
    output rdata
  );

endinterface

//--- hdl/alu.sv
`timescale 1ns/1ps

module alu (
  input  mc_pkg::word_t   a,
  input  mc_pkg::word_t   b,
  input  mc_pkg::alu_op_t op,
  output mc_pkg::word_t   y,
  output logic            zero
);
  import mc_pkg::*;

  word_t diff;

  assign diff = a - b;

  always_comb begin
    case (op)
      ALU_ADD:    y = a + b;
      ALU_SUB:    y = diff;
      ALU_AND:    y = a & b;
      ALU_OR:     y = a | b;
      ALU_XOR:    y = a ^ b;
      // Signed compare.
      ALU_SLT:    y = {31'b0, $signed(a) < $signed(b)};
      ALU_PASS_B: y = b;
      default:    y = '0;
    endcase
  end

  assign zero = (y == '0);

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic          clk,
  input  logic          arst_n,
  input  logic [4:0]    ra1,
  input  logic [4:0]    ra2,
  input  logic [4:0]    wa,
  input  logic          we,
  input  mc_pkg::word_t wd,
  output mc_pkg::word_t rd1,
  output mc_pkg::word_t rd2
);
  import mc_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wa != 5'd0) begin
      regs[wa] <= wd;
    end
  end

  // x0 is hardwired.
  assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

  assert property (@(posedge clk) disable iff (!arst_n)
    (we && wa == 5'd0) |=> (regs[0] == '0));

endmodule

//--- hdl/control_fsm.sv
`timescale 1ns/1ps

module control_fsm (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                run,
  input  mc_pkg::instr_u      instr,
  input  logic                zero,
  mem_if.requester_ctrl       mem,
  output logic                pc_write,
  output logic                ir_write,
  output logic                reg_write,
  output logic                branch,
  output mc_pkg::adr_src_t    adr_src,
  output mc_pkg::alu_src_a_t  alu_src_a,
  output mc_pkg::alu_src_b_t  alu_src_b,
  output mc_pkg::result_src_t result_src,
  output mc_pkg::alu_op_t     alu_op,
  output logic                halted
);
  import mc_pkg::*;

  fsm_state_t state;
  fsm_state_t next;

  // ALU operation from funct3 and the funct7 bit of R-type.
  function automatic alu_op_t funct_op(input instr_u ins, input logic is_r);
    alu_op_t op;
    case (ins.r_fmt.funct3)
      3'b000:  op = (is_r && ins.r_fmt.funct7[5]) ? ALU_SUB : ALU_ADD;
      3'b010:  op = ALU_SLT;
      3'b100:  op = ALU_XOR;
      3'b110:  op = ALU_OR;
      3'b111:  op = ALU_AND;
      default: op = ALU_ADD;
    endcase
    return op;
  endfunction

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= S_IDLE;
    end else begin
      state <= next;
    end
  end

  always_comb begin
    next = state;
    case (state)
      S_IDLE:       if (run) next = S_FETCH;
      S_FETCH:      if (mem.gnt) next = S_FETCH_WAIT;
      S_FETCH_WAIT: next = S_DECODE;
      S_DECODE: begin
        case (instr.r_fmt.opcode)
          OPC_OP:     next = S_EXEC_R;
          OPC_OP_IMM: next = S_EXEC_I;
          OPC_LUI:    next = S_ALU_WB;
          OPC_BRANCH: next = S_BRANCH;
          OPC_JAL:    next = S_JUMP;
          OPC_LOAD:   next = S_MEM_RD;
          OPC_STORE:  next = S_MEM_WR;
          OPC_SYSTEM: next = S_HALT;
          default:    next = S_FETCH;
        endcase
      end
      S_MEM_RD:     if (mem.gnt) next = S_MEM_WB;
      S_MEM_WR:     if (mem.gnt) next = S_FETCH;
      S_EXEC_R, S_EXEC_I, S_ALU_WB, S_BRANCH, S_JUMP, S_MEM_WB: next = S_FETCH;
      S_HALT:       next = S_HALT;
      default:      next = S_IDLE;
    endcase
  end

  always_comb begin
    mem.req    = 1'b0;
    mem.we     = 1'b0;
    pc_write   = 1'b0;
    ir_write   = 1'b0;
    reg_write  = 1'b0;
    branch     = 1'b0;
    adr_src    = ADR_PC;
    alu_src_a  = SRC_A_PC;
    alu_src_b  = SRC_B_FOUR;
    result_src = RES_ALU_RESULT;
    alu_op     = ALU_ADD;
    case (state)
      S_FETCH: mem.req = 1'b1;
      S_FETCH_WAIT: begin
        ir_write = 1'b1;
        pc_write = 1'b1;
      end
      // Target from old PC for branch and jal.
      S_DECODE: begin
        alu_src_a = SRC_A_OLD_PC;
        alu_src_b = SRC_B_IMM;
        pc_write  = (instr.r_fmt.opcode == OPC_JAL);
      end
      S_EXEC_R: begin
        alu_src_a = SRC_A_RS1;
        alu_src_b = SRC_B_RS2;
        alu_op    = funct_op(instr, 1'b1);
        reg_write = 1'b1;
      end
      S_EXEC_I: begin
        alu_src_a = SRC_A_RS1;
        alu_src_b = SRC_B_IMM;
        alu_op    = funct_op(instr, 1'b0);
        reg_write = 1'b1;
      end
      S_ALU_WB: begin
        alu_src_a = SRC_A_ZERO;
        alu_src_b = SRC_B_IMM;
        alu_op    = ALU_PASS_B;
        reg_write = 1'b1;
      end
      // beq on zero, bne on nonzero.
      S_BRANCH: begin
        alu_src_a  = SRC_A_RS1;
        alu_src_b  = SRC_B_RS2;
        alu_op     = ALU_SUB;
        result_src = RES_ALU_OUT;
        branch     = zero ^ instr.b_fmt.funct3[0];
      end
      S_JUMP: begin
        alu_src_a = SRC_A_OLD_PC;
        reg_write = 1'b1;
      end
      S_MEM_RD, S_MEM_WR: begin
        alu_src_a = SRC_A_RS1;
        alu_src_b = SRC_B_IMM;
        adr_src   = ADR_RESULT;
        mem.req   = 1'b1;
        mem.we    = (state == S_MEM_WR);
      end
      S_MEM_WB: begin
        result_src = RES_DATA;
        reg_write  = 1'b1;
      end
      default: ;
    endcase
  end

  assign halted = (state == S_HALT);

  assert property (@(posedge clk) disable iff (!arst_n)
    !$isunknown(state) && state inside {[S_IDLE:S_HALT]});

  // No writeback while a memory request still waits for the arbiter.
  assert property (@(posedge clk) disable iff (!arst_n)
    (mem.req && !mem.gnt) |-> !reg_write);

endmodule

//--- hdl/datapath.sv
`timescale 1ns/1ps

module datapath (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                pc_write,
  input  logic                ir_write,
  input  logic                reg_write,
  input  logic                branch,
  input  mc_pkg::adr_src_t    adr_src,
  input  mc_pkg::alu_src_a_t  alu_src_a,
  input  mc_pkg::alu_src_b_t  alu_src_b,
  input  mc_pkg::result_src_t result_src,
  input  mc_pkg::alu_op_t     alu_op,
  output mc_pkg::instr_u      instr,
  output logic                zero,
  mem_if.requester_data       mem
);
  import mc_pkg::*;

  word_t  pc_q;
  word_t  old_pc_q;
  instr_u ir_q;
  word_t  rd1;
  word_t  rd2;
  word_t  rs1_q;
  word_t  rs2_q;
  word_t  imm;
  word_t  src_a;
  word_t  src_b;
  word_t  alu_y;
  word_t  alu_out_q;
  word_t  result;

  assign instr = ir_q;

  // Branch strobe comes already qualified by the condition.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_q     <= '0;
      old_pc_q <= '0;
      ir_q     <= '0;
    end else begin
      if (pc_write || branch) begin
        pc_q <= result;
      end
      if (ir_write) begin
        ir_q     <= mem.rdata;
        old_pc_q <= pc_q;
      end
    end
  end

  always_ff @(posedge clk) begin
    rs1_q     <= rd1;
    rs2_q     <= rd2;
    alu_out_q <= alu_y;
  end

  always_comb begin
    case (ir_q.r_fmt.opcode)
      OPC_OP_IMM, OPC_LOAD: imm = {{20{ir_q.i_fmt.imm[11]}}, ir_q.i_fmt.imm};
      OPC_STORE: imm = {{20{ir_q.s_fmt.imm_11_5[6]}}, ir_q.s_fmt.imm_11_5, ir_q.s_fmt.imm_4_0};
      OPC_BRANCH: imm = {{19{ir_q.b_fmt.imm_12}}, ir_q.b_fmt.imm_12, ir_q.b_fmt.imm_11,
                         ir_q.b_fmt.imm_10_5, ir_q.b_fmt.imm_4_1, 1'b0};
      OPC_JAL: imm = {{11{ir_q.j_fmt.imm_20}}, ir_q.j_fmt.imm_20, ir_q.j_fmt.imm_19_12,
                      ir_q.j_fmt.imm_11, ir_q.j_fmt.imm_10_1, 1'b0};
      OPC_LUI: imm = {ir_q.u_fmt.imm_31_12, 12'b0};
      default: imm = '0;
    endcase
  end

  reg_file u_reg_file (
    .clk    (clk),
    .arst_n (arst_n),
    .ra1    (ir_q.r_fmt.rs1),
    .ra2    (ir_q.r_fmt.rs2),
    .wa     (ir_q.r_fmt.rd),
    .we     (reg_write),
    .wd     (result),
    .rd1    (rd1),
    .rd2    (rd2)
  );

  always_comb begin
    case (alu_src_a)
      SRC_A_PC:     src_a = pc_q;
      SRC_A_OLD_PC: src_a = old_pc_q;
      SRC_A_RS1:    src_a = rs1_q;
      default:      src_a = '0;
    endcase
  end

  always_comb begin
    case (alu_src_b)
      SRC_B_RS2:  src_b = rs2_q;
      SRC_B_IMM:  src_b = imm;
      SRC_B_FOUR: src_b = 32'd4;
      default:    src_b = '0;
    endcase
  end

  alu u_alu (
    .a    (src_a),
    .b    (src_b),
    .op   (alu_op),
    .y    (alu_y),
    .zero (zero)
  );

  // Load data comes straight off the RAM output register.
  always_comb begin
    case (result_src)
      RES_ALU_OUT: result = alu_out_q;
      RES_DATA:    result = mem.rdata;
      default:     result = alu_y;
    endcase
  end

  assign mem.addr  = (adr_src == ADR_PC) ? pc_q : result;
  assign mem.wdata = rs2_q;

endmodule

//--- hdl/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
  input  logic                                  clk,
  input  logic                                  arst_n,
  mem_if.arbiter                                core,
  input  logic                                  host_req,
  input  logic                                  host_we,
  input  mc_pkg::word_t                         host_addr,
  input  mc_pkg::word_t                         host_wdata,
  output logic                                  host_gnt,
  output mc_pkg::word_t                         host_rdata,
  output logic                                  mem_en,
  output logic                                  mem_we,
  output logic [$clog2(mc_pkg::MEM_WORDS)-1:0]  mem_addr,
  output mc_pkg::word_t                         mem_wdata,
  input  mc_pkg::word_t                         mem_rdata
);
  import mc_pkg::*;

  logic host_owner_q;

  // Host always wins.
  assign host_gnt = host_req;
  assign core.gnt = core.req && !host_req;

  // Both sides use byte addresses.
  assign mem_en    = host_req || core.req;
  assign mem_we    = host_req ? host_we : core.we;
  assign mem_addr  = host_req ? host_addr[$clog2(MEM_WORDS)+1:2]
                              : core.addr[$clog2(MEM_WORDS)+1:2];
  assign mem_wdata = host_req ? host_wdata : core.wdata;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      host_owner_q <= 1'b0;
    end else begin
      host_owner_q <= host_req;
    end
  end

  assign host_rdata = host_owner_q ? mem_rdata : '0;
  assign core.rdata = host_owner_q ? '0 : mem_rdata;

  assert property (@(posedge clk) disable iff (!arst_n) !(host_gnt && core.gnt));

endmodule

//--- hdl/unified_mem.sv
`timescale 1ns/1ps

module unified_mem (
  input  logic                                 clk,
  input  logic                                 en,
  input  logic                                 we,
  input  logic [$clog2(mc_pkg::MEM_WORDS)-1:0] addr,
  input  mc_pkg::word_t                        wdata,
  output mc_pkg::word_t                        rdata
);
  import mc_pkg::*;

  word_t ram [MEM_WORDS];

  // Read returns the old word on a write.
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        ram[addr] <= wdata;
      end
      rdata <= ram[addr];
    end
  end

endmodule

//--- hdl/mc_core_top.sv
`timescale 1ns/1ps

module mc_core_top (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          run,
  input  logic          host_req,
  input  logic          host_we,
  input  mc_pkg::word_t host_addr,
  input  mc_pkg::word_t host_wdata,
  output logic          host_gnt,
  output mc_pkg::word_t host_rdata,
  output logic          halted
);
  import mc_pkg::*;

  instr_u      instr;
  logic        zero;
  logic        pc_write;
  logic        ir_write;
  logic        reg_write;
  logic        branch;
  adr_src_t    adr_src;
  alu_src_a_t  alu_src_a;
  alu_src_b_t  alu_src_b;
  result_src_t result_src;
  alu_op_t     alu_op;
  logic        mem_en;
  logic        mem_we;
  logic [$clog2(MEM_WORDS)-1:0] mem_addr;
  word_t       mem_wdata;
  word_t       mem_rdata;

  mem_if core_mem ();

  control_fsm u_control_fsm (
    .clk        (clk),
    .arst_n     (arst_n),
    .run        (run),
    .instr      (instr),
    .zero       (zero),
    .mem        (core_mem.requester_ctrl),
    .pc_write   (pc_write),
    .ir_write   (ir_write),
    .reg_write  (reg_write),
    .branch     (branch),
    .adr_src    (adr_src),
    .alu_src_a  (alu_src_a),
    .alu_src_b  (alu_src_b),
    .result_src (result_src),
    .alu_op     (alu_op),
    .halted     (halted)
  );

  datapath u_datapath (
    .clk        (clk),
    .arst_n     (arst_n),
    .pc_write   (pc_write),
    .ir_write   (ir_write),
    .reg_write  (reg_write),
    .branch     (branch),
    .adr_src    (adr_src),
    .alu_src_a  (alu_src_a),
    .alu_src_b  (alu_src_b),
    .result_src (result_src),
    .alu_op     (alu_op),
    .instr      (instr),
    .zero       (zero),
    .mem        (core_mem.requester_data)
  );

  mem_arbiter u_mem_arbiter (
    .clk        (clk),
    .arst_n     (arst_n),
    .core       (core_mem.arbiter),
    .host_req   (host_req),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_gnt   (host_gnt),
    .host_rdata (host_rdata),
    .mem_en     (mem_en),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_rdata  (mem_rdata)
  );

  unified_mem u_unified_mem (
    .clk   (clk),
    .en    (mem_en),
    .we    (mem_we),
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .rdata (mem_rdata)
  );

endmodule

//--- verif/tb_core.sv
`timescale 1ns/1ps

module tb_core;

  logic        clk;
  logic        arst_n;
  logic        run;
  logic        host_req;
  logic        host_we;
  logic [31:0] host_addr;
  logic [31:0] host_wdata;
  logic        host_gnt;
  logic [31:0] host_rdata;
  logic        halted;

  int unsigned cycles;
  int          checks;
  int          errors;
  int          tests;
  int          test_checks;
  int          test_errors;
  logic [15:0] lfsr_q;

  logic [31:0] prog[$];
  logic [31:0] exp_addr[$];
  logic [31:0] exp_val[$];
  logic [31:0] next_slot;

  mc_core_top DUT (
    .clk        (clk),
    .arst_n     (arst_n),
    .run        (run),
    .host_req   (host_req),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_gnt   (host_gnt),
    .host_rdata (host_rdata),
    .halted     (halted)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // The random test takes most of the cycle budget.
  initial begin
    cycles = 0;
    while (cycles < 4000) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the tests did not finish within 4000 cycles");
    $display("Testbench failed");
    $finish;
  end

  assert property (@(posedge clk) disable iff (!arst_n) host_gnt == host_req)
    else begin
      $display("Host grant did not follow the host request at %0t", $time);
      errors++;
    end

  assert property (@(posedge clk) disable iff (!arst_n) halted |=> halted)
    else begin
      $display("Halted dropped without a reset at %0t", $time);
      errors++;
    end

  assert property (@(posedge clk) disable iff (!arst_n) !(host_gnt && DUT.core_mem.gnt))
    else begin
      $display("Host and core were granted in the same cycle at %0t", $time);
      errors++;
    end

  // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic lsb;
    lsb = s[0];
    s = s >> 1;
    if (lsb) begin
      s = s ^ 16'hb400;
    end
    return s;
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[31:16] ^ addr[15:0] ^ 16'h5a5a, ~addr[15:0]};
  endfunction

  // RV32I arithmetic by funct3.
  function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic sub,
                                            input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return sub ? a - b : a + b;
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      3'b111:  return a & b;
      default: return 32'd0;
    endcase
  endfunction

  function automatic logic [31:0] alu_reg(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] alu_imm(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] load_word(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] off);
    return {off, rs1, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                             input logic [11:0] off);
    return {off[11:5], rs2, rs1, 3'b010, off[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] branch_op(input logic [2:0] f3, input logic [4:0] rs1,
                                            input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal_op(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] lui_op(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp)
      else begin
        $display("Fail %s: expected %h, actual %h", name, exp, act);
        errors++;
      end
  endtask

  task automatic host_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk);
    host_req   <= 1'b1;
    host_we    <= 1'b1;
    host_addr  <= addr;
    host_wdata <= data;
    do begin
      @(posedge clk);
    end while (!host_gnt);
    host_req <= 1'b0;
    host_we  <= 1'b0;
  endtask

  task automatic host_read(input logic [31:0] addr, output logic [31:0] data);
    @(posedge clk);
    host_req  <= 1'b1;
    host_we   <= 1'b0;
    host_addr <= addr;
    do begin
      @(posedge clk);
    end while (!host_gnt);
    host_req <= 1'b0;
    // Data shows up one cycle after the grant.
    @(negedge clk);
    data = host_rdata;
  endtask

  task automatic reset_dut();
    @(posedge clk);
    arst_n   <= 1'b0;
    run      <= 1'b0;
    host_req <= 1'b0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
  endtask

  task automatic new_program();
    prog.delete();
    exp_addr.delete();
    exp_val.delete();
    next_slot = 32'h200;
  endtask

  task automatic emit_store(input logic [4:0] rs2, input logic [31:0] exp);
    prog.push_back(store_word(rs2, 5'd0, next_slot[11:0]));
    exp_addr.push_back(next_slot);
    exp_val.push_back(exp);
    next_slot = next_slot + 32'd4;
  endtask

  // Operands sit in x1 and x2 and the result goes through x3.
  task automatic emit_r_op(input logic [2:0] f3, input logic sub,
                           input logic [31:0] a, input logic [31:0] b);
    prog.push_back(alu_reg(sub ? 7'h20 : 7'h00, f3, 5'd3, 5'd1, 5'd2));
    emit_store(5'd3, model_alu(f3, sub, a, b));
  endtask

  task automatic emit_i_op(input logic [2:0] f3, input logic [4:0] rs1,
                           input logic [11:0] imm, input logic [31:0] a);
    prog.push_back(alu_imm(f3, 5'd3, rs1, imm));
    emit_store(5'd3, model_alu(f3, 1'b0, a, sext12(imm)));
  endtask

  task automatic prepare_program();
    reset_dut();
    for (int i = 0; i < prog.size(); i++) begin
      host_write(i * 4, prog[i]);
    end
    // Stale results must not pass.
    for (int i = 0; i < exp_addr.size(); i++) begin
      host_write(exp_addr[i], fill_word(exp_addr[i]));
    end
  endtask

  task automatic run_to_halt();
    @(posedge clk);
    run <= 1'b1;
    while (!halted) begin
      @(negedge clk);
    end
    @(posedge clk);
    run <= 1'b0;
  endtask

  task automatic check_results(input string name);
    logic [31:0] got;
    for (int i = 0; i < exp_addr.size(); i++) begin
      host_read(exp_addr[i], got);
      check_word($sformatf("%s word %0d", name, i), exp_val[i], got);
    end
  endtask

  task automatic begin_test();
    test_checks = checks;
    test_errors = errors;
  endtask

  task automatic end_test(input string name);
    int n_checks;
    int n_errors;
    n_checks = checks - test_checks;
    n_errors = errors - test_errors;
    tests++;
    $display("%s: %s, %0d checks, %0d errors", name, (n_errors == 0) ? "ok" : "FAILED",
             n_checks, n_errors);
  endtask

  task automatic build_loop_prog();
    logic [31:0] sum;
    int          loop_idx;
    sum = 32'd0;
    for (int i = 1; i <= 10; i++) begin
      sum = sum + 32'(i);
    end
    new_program();
    prog.push_back(alu_imm(3'b000, 5'd1, 5'd0, 12'd0));
    prog.push_back(alu_imm(3'b000, 5'd2, 5'd0, 12'd1));
    prog.push_back(alu_imm(3'b000, 5'd4, 5'd0, 12'd11));
    loop_idx = prog.size();
    prog.push_back(alu_reg(7'h00, 3'b000, 5'd1, 5'd1, 5'd2));
    prog.push_back(alu_imm(3'b000, 5'd2, 5'd2, 12'd1));
    prog.push_back(branch_op(3'b001, 5'd2, 5'd4, 13'((loop_idx - prog.size()) * 4)));
    // Not taken and falls through to the addi.
    prog.push_back(branch_op(3'b000, 5'd1, 5'd0, 13'd8));
    prog.push_back(alu_imm(3'b000, 5'd5, 5'd0, 12'd77));
    // Taken and skips the addi to x6.
    prog.push_back(branch_op(3'b000, 5'd0, 5'd0, 13'd8));
    prog.push_back(alu_imm(3'b000, 5'd6, 5'd0, 12'd1));
    emit_store(5'd1, sum);
    emit_store(5'd5, 32'd77);
    emit_store(5'd6, 32'd0);
    prog.push_back(32'h0010_0073);
  endtask

  task automatic host_round_trip();
    logic [31:0] data [16];
    logic [31:0] got;
    begin_test();
    for (int i = 0; i < 16; i++) begin
      rand_bits(32, data[i]);
      host_write(32'h100 + i * 44, data[i]);
    end
    for (int i = 0; i < 16; i++) begin
      host_read(32'h100 + i * 44, got);
      check_word($sformatf("host word %0d", i), data[i], got);
    end
    end_test("host round trip");
  endtask

  task automatic alu_program();
    logic [11:0] imm_a;
    logic [11:0] imm_b;
    logic [31:0] a;
    logic [31:0] b;
    begin_test();
    imm_a = 12'd1234;
    imm_b = 12'hdc9;
    a = sext12(imm_a);
    b = sext12(imm_b);
    new_program();
    prog.push_back(alu_imm(3'b000, 5'd1, 5'd0, imm_a));
    prog.push_back(alu_imm(3'b000, 5'd2, 5'd0, imm_b));
    emit_r_op(3'b000, 1'b0, a, b);
    emit_r_op(3'b000, 1'b1, a, b);
    emit_r_op(3'b111, 1'b0, a, b);
    emit_r_op(3'b110, 1'b0, a, b);
    emit_r_op(3'b100, 1'b0, a, b);
    emit_r_op(3'b010, 1'b0, a, b);
    emit_i_op(3'b000, 5'd1, 12'hf9c, a);
    emit_i_op(3'b010, 5'd1, 12'd2000, a);
    emit_i_op(3'b010, 5'd2, 12'd5, b);
    emit_i_op(3'b100, 5'd1, 12'hf9c, a);
    emit_i_op(3'b110, 5'd2, 12'h0f0, b);
    emit_i_op(3'b111, 5'd1, 12'h0ff, a);
    prog.push_back(lui_op(5'd3, 20'habcde));
    emit_store(5'd3, {20'habcde, 12'h000});
    prog.push_back(32'h0010_0073);
    prepare_program();
    run_to_halt();
    check_results("alu");
    end_test("alu program");
  endtask

  task automatic branch_loop();
    begin_test();
    build_loop_prog();
    prepare_program();
    run_to_halt();
    check_results("loop");
    end_test("branch loop");
  endtask

  task automatic load_jal_x0();
    logic [31:0] data;
    logic [31:0] link_pc;
    begin_test();
    rand_bits(32, data);
    new_program();
    prog.push_back(load_word(5'd1, 5'd0, 12'h300));
    prog.push_back(alu_imm(3'b000, 5'd2, 5'd1, 12'd25));
    emit_store(5'd2, data + 32'd25);
    link_pc = prog.size() * 4;
    prog.push_back(jal_op(5'd5, 21'd8));
    prog.push_back(alu_imm(3'b000, 5'd6, 5'd0, 12'd1));
    emit_store(5'd5, link_pc + 32'd4);
    prog.push_back(alu_imm(3'b000, 5'd0, 5'd0, 12'd99));
    emit_store(5'd0, 32'd0);
    emit_store(5'd6, 32'd0);
    prog.push_back(32'h0010_0073);
    prepare_program();
    host_write(32'h300, data);
    run_to_halt();
    check_results("load jal x0");
    end_test("load, jal and x0");
  endtask

  task automatic contention();
    logic [31:0] paddr;
    logic [31:0] got;
    logic        done;
    int          k;
    begin_test();
    build_loop_prog();
    prepare_program();
    for (int i = 0; i < 8; i++) begin
      host_write(32'h380 + i * 4, fill_word(32'h380 + i * 4));
    end
    @(posedge clk);
    run <= 1'b1;
    k = 0;
    done = 1'b0;
    // One host read every third cycle.
    while (!done) begin
      paddr = 32'h380 + (k % 8) * 4;
      host_read(paddr, got);
      check_word("contention read", fill_word(paddr), got);
      k++;
      done = halted;
      @(posedge clk);
    end
    run <= 1'b0;
    check_results("contention");
    end_test("contention");
  endtask

  task automatic random_operands();
    logic [31:0] r;
    logic [11:0] imm_a;
    logic [11:0] imm_b;
    logic [31:0] a;
    logic [31:0] b;
    begin_test();
    repeat (20) begin
      rand_bits(12, r);
      imm_a = r[11:0];
      rand_bits(12, r);
      imm_b = r[11:0];
      a = sext12(imm_a);
      b = sext12(imm_b);
      new_program();
      prog.push_back(alu_imm(3'b000, 5'd1, 5'd0, imm_a));
      prog.push_back(alu_imm(3'b000, 5'd2, 5'd0, imm_b));
      emit_r_op(3'b000, 1'b0, a, b);
      emit_r_op(3'b000, 1'b1, a, b);
      emit_r_op(3'b100, 1'b0, a, b);
      emit_r_op(3'b010, 1'b0, a, b);
      prog.push_back(32'h0010_0073);
      prepare_program();
      run_to_halt();
      check_results($sformatf("random %h %h", imm_a, imm_b));
    end
    end_test("random operands");
  endtask

  initial begin
    arst_n     = 1'b0;
    run        = 1'b0;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    checks     = 0;
    errors     = 0;
    tests      = 0;
    lfsr_q     = 16'd4608;
    reset_dut();
    host_round_trip();
    alu_program();
    branch_loop();
    load_jal_x0();
    contention();
    random_operands();
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- build.f
hdl/mc_pkg.sv
hdl/mem_if.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/control_fsm.sv
hdl/datapath.sv
hdl/mem_arbiter.sv
hdl/unified_mem.sv
hdl/mc_core_top.sv
verif/tb_core.sv

//--- Bender.yml
package:
  name: mc_core

sources:
  - hdl/mc_pkg.sv
  - hdl/mem_if.sv
  - hdl/alu.sv
  - hdl/reg_file.sv
  - hdl/control_fsm.sv
  - hdl/datapath.sv
  - hdl/mem_arbiter.sv
  - hdl/unified_mem.sv
  - hdl/mc_core_top.sv
  - target: simulation
    files:
      - verif/tb_core.sv
